// File: compile.f
ulpi_pkg.sv
ulpi_txcmd_if.sv
ulpi_rx_decoder.sv
ulpi_tx_engine.sv
ulpi_link_fsm.sv
usb2_ulpi_link.sv
tb_usb2_ulpi_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the link and its testbench with Verilator, then run the simulation
# a failed build or a failed check gives a non-zero exit status
cd "$(dirname "$0")" &&
   verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_usb2_ulpi_link -f compile.f -o tb_usb2_ulpi_link &&
   ./obj_dir/tb_usb2_ulpi_link ||
   { echo "simulation run failed" >&2; exit 1; }

// File: tb_usb2_ulpi_link.sv
/*
 * Testbench for the full-speed ULPI device link. A small PHY model
 * answers TX_CMD bytes with NXT and sends RX_CMDs, while a step table
 * walks start-up, receive, transmit, bus reset and Vbus loss.
 */
`default_nettype none

module tb_usb2_ulpi_link;
   timeunit 1ns;
   timeprecision 1ps;
   import ulpi_pkg::*;

   localparam int TICK_CYCLES       = 4;
   localparam int DEBOUNCE_TICKS    = 3;
   localparam int SE0_RESET_TICKS   = 5;
   localparam int PHY_RESET_TIMEOUT = 20;
   localparam int RESET_CYCLES      = 5;
   localparam int DISABLE_CYCLES    = 8;
   localparam int NSTEPS            = 17;
   // worst step is a full debounce plus a missed PHY reset
   localparam int STEP_CYCLES = TICK_CYCLES * (DEBOUNCE_TICKS + SE0_RESET_TICKS)
                                + PHY_RESET_TIMEOUT + 40;
   localparam int CYCLE_LIMIT = RESET_CYCLES + DISABLE_CYCLES + NSTEPS * STEP_CYCLES;

   ////////////////////
   // step kinds
   localparam logic [2:0] OP_REGWR = 3'd0;  // a cmd byte, b data byte
   localparam logic [2:0] OP_RXCMD = 3'd1;  // a RX_CMD, flag stat_connected
   localparam logic [2:0] OP_LOCAL = 3'd2;  // flag is reset_local
   localparam logic [2:0] OP_RECV  = 3'd3;  // b byte count
   localparam logic [2:0] OP_XMIT  = 3'd4;  // a PID byte, b payload count
   localparam logic [2:0] OP_SE0   = 3'd5;

   typedef struct packed {
      logic [2:0] op;
      ulpi_byte_t a;
      ulpi_byte_t b;
      logic       flag;
   } step_t;

   step_t       steps [NSTEPS];
   logic [31:0] lfsr_state;
   int          cycles = 0;

   logic       clk_suspend, reset_2, opt_disable_all, opt_ignore_vbus;
   logic       phy_dir, phy_nxt, pkt_in_latch, pkt_in_stp;
   ulpi_byte_t phy_d_in, pkt_in_byte;
   logic       reset_local, stat_connected, phy_d_oe, phy_stp, se0_reset;
   logic       pkt_out_act, pkt_out_latch, pkt_in_cts, pkt_in_nxt;
   ulpi_byte_t phy_d_out_mux, pkt_out_byte;

   usb2_ulpi_link #(
      .TICK_CYCLES       (TICK_CYCLES),
      .DEBOUNCE_TICKS    (DEBOUNCE_TICKS),
      .SE0_RESET_TICKS   (SE0_RESET_TICKS),
      .PHY_RESET_TIMEOUT (PHY_RESET_TIMEOUT)
   ) UUT (
      .clk_suspend, .reset_2, .reset_local, .opt_disable_all, .opt_ignore_vbus,
      .stat_connected, .phy_d_in, .phy_d_out_mux, .phy_d_oe, .phy_dir, .phy_stp,
      .phy_nxt, .pkt_out_act, .pkt_out_byte, .pkt_out_latch, .pkt_in_cts,
      .pkt_in_nxt, .pkt_in_byte, .pkt_in_latch, .pkt_in_stp, .se0_reset
   );

   always #20 clk_suspend = ~clk_suspend;

   // watchdog
   always @(posedge clk_suspend) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         stop_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   ////////////////////
   // compare tasks
   task automatic check_byte(input string name, input ulpi_byte_t got, input ulpi_byte_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[ERROR] %0t %s got %02h expected %02h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_rx(input string name, input rx_cmd_t got, input rx_cmd_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[ERROR] %0t %s got %02h expected %02h", $time, name, got, exp));
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output ulpi_byte_t v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[6:0], lfsr_state[0]};
      end
   endtask

   task automatic check_outputs_idle();
      check_bit("phy_stp", phy_stp, 1'b0);
      check_bit("pkt_out_act", pkt_out_act, 1'b0);
      check_bit("pkt_out_latch", pkt_out_latch, 1'b0);
      check_bit("pkt_in_cts", pkt_in_cts, 1'b0);
      check_bit("pkt_in_nxt", pkt_in_nxt, 1'b0);
      check_bit("se0_reset", se0_reset, 1'b0);
      check_bit("reset_local", reset_local, 1'b0);
      check_byte("phy_d_out_mux", phy_d_out_mux, 8'h00);
   endtask

   task automatic wait_for_command();
      do @(negedge clk_suspend); while (phy_d_out_mux == 8'h00);
   endtask

   ////////////////////
   // PHY answers cmd and data with NXT and then sees STP
   task automatic expect_regwr(input ulpi_byte_t cmd, input ulpi_byte_t data);
      wait_for_command();
      check_byte("phy_d_out_mux", phy_d_out_mux, cmd);
      @(posedge clk_suspend);
      phy_nxt <= 1'b1;
      @(negedge clk_suspend);
      check_byte("phy_d_out_mux", phy_d_out_mux, cmd);
      @(negedge clk_suspend);
      check_byte("phy_d_out_mux", phy_d_out_mux, data);
      @(posedge clk_suspend);
      phy_nxt <= 1'b0;
      @(negedge clk_suspend);
      check_bit("phy_stp", phy_stp, 1'b1);
      check_byte("phy_d_out_mux", phy_d_out_mux, 8'h00);
      @(negedge clk_suspend);
      check_bit("phy_stp", phy_stp, 1'b0);
   endtask

   // turnaround then one RX_CMD byte and DIR low again
   task automatic send_rx_cmd(input ulpi_byte_t value, input logic connected);
      @(posedge clk_suspend);
      phy_dir  <= 1'b1;
      phy_nxt  <= 1'b0;
      phy_d_in <= 8'h00;
      @(posedge clk_suspend);
      phy_d_in <= value;
      @(negedge clk_suspend);
      check_bit("phy_d_oe", phy_d_oe, 1'b0);
      @(posedge clk_suspend);
      phy_dir  <= 1'b0;
      phy_d_in <= 8'h00;
      @(negedge clk_suspend);
      check_rx("rx_cmd", UUT.u_rx.rx_cmd, rx_cmd_t'(value));
      check_bit("stat_connected", stat_connected, connected);
   endtask

   task automatic receive_packet(input int n);
      ulpi_byte_t data;
      // DIR and NXT together start a receive
      @(posedge clk_suspend);
      phy_dir  <= 1'b1;
      phy_nxt  <= 1'b1;
      phy_d_in <= 8'h00;
      @(negedge clk_suspend);
      check_bit("pkt_out_latch", pkt_out_latch, 1'b0);
      for (int i = 0; i < n; i++) begin
         take_bits(8, data);
         @(posedge clk_suspend);
         phy_d_in <= data;
         @(negedge clk_suspend);
         check_bit("pkt_out_act", pkt_out_act, 1'b1);
         check_bit("pkt_out_latch", pkt_out_latch, 1'b1);
         check_byte("pkt_out_byte", pkt_out_byte, data);
      end
      @(posedge clk_suspend);
      phy_dir  <= 1'b0;
      phy_nxt  <= 1'b0;
      phy_d_in <= 8'h00;
      @(negedge clk_suspend);
      check_bit("pkt_out_act", pkt_out_act, 1'b0);
      check_bit("pkt_out_latch", pkt_out_latch, 1'b0);
   endtask

   task automatic transmit_packet(input ulpi_byte_t pid_byte, input int n);
      ulpi_byte_t pay [$];
      ulpi_byte_t b;
      int         i;
      for (int k = 0; k < n; k++) begin
         take_bits(8, b);
         pay.push_back(b);
      end
      do @(negedge clk_suspend); while (pkt_in_cts !== 1'b1);
      @(posedge clk_suspend);
      pkt_in_latch <= 1'b1;
      pkt_in_byte  <= pid_byte;
      @(posedge clk_suspend);
      pkt_in_latch <= 1'b0;
      wait_for_command();
      // XMIT class with the PID nibble
      check_byte("phy_d_out_mux", phy_d_out_mux, 8'h40 | {4'h0, pid_byte[3:0]});
      @(posedge clk_suspend);
      phy_nxt     <= 1'b1;
      pkt_in_byte <= pay[0];
      @(negedge clk_suspend);
      check_bit("pkt_in_nxt", pkt_in_nxt, 1'b0);
      i = 0;
      while (i < n) begin
         @(negedge clk_suspend);
         check_byte("phy_d_out_mux", phy_d_out_mux, pay[i]);
         check_bit("pkt_in_nxt", pkt_in_nxt, phy_nxt);
         if (phy_nxt) i++;
         // random back-pressure
         take_bits(1, b);
         @(posedge clk_suspend);
         if (i < n) pkt_in_byte <= pay[i];
         else pkt_in_byte <= 8'h00;
         phy_nxt    <= (i < n) & b[0];
         pkt_in_stp <= (i == n);
      end
      @(posedge clk_suspend);
      pkt_in_stp <= 1'b0;
      @(negedge clk_suspend);
      check_bit("phy_stp", phy_stp, 1'b1);
      @(negedge clk_suspend);
      check_bit("phy_stp", phy_stp, 1'b0);
   endtask

   initial begin
      clk_suspend     = 1'b0;
      reset_2         = 1'b0;
      opt_disable_all = 1'b1;
      opt_ignore_vbus = 1'b0;
      phy_dir         = 1'b0;
      phy_nxt         = 1'b0;
      phy_d_in        = 8'h00;
      pkt_in_byte     = 8'h00;
      pkt_in_latch    = 1'b0;
      pkt_in_stp      = 1'b0;
      lfsr_state      = 32'h3cf2_d20a;
      // RX_CMD 0D is Vbus valid with J, 0C is SE0, 05 is Vbus below valid
      steps = '{
         '{OP_REGWR, 8'h84, 8'h65, 1'b0}, '{OP_RXCMD, 8'h0D, 8'h00, 1'b1},
         '{OP_REGWR, 8'h8A, 8'h00, 1'b0}, '{OP_LOCAL, 8'h00, 8'h00, 1'b1},
         '{OP_RECV,  8'h00, 8'd4,  1'b0}, '{OP_XMIT,  8'hC3, 8'd5,  1'b0},
         '{OP_RXCMD, 8'h0C, 8'h00, 1'b1}, '{OP_SE0,   8'h00, 8'h00, 1'b0},
         '{OP_REGWR, 8'h84, 8'h45, 1'b0}, '{OP_RXCMD, 8'h0D, 8'h00, 1'b1},
         '{OP_XMIT,  8'h4B, 8'd3,  1'b0}, '{OP_RXCMD, 8'h05, 8'h00, 1'b0},
         '{OP_LOCAL, 8'h00, 8'h00, 1'b0}, '{OP_REGWR, 8'h84, 8'h65, 1'b0},
         '{OP_RXCMD, 8'h0D, 8'h00, 1'b1}, '{OP_REGWR, 8'h8A, 8'h00, 1'b0},
         '{OP_LOCAL, 8'h00, 8'h00, 1'b1}
      };

      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk_suspend);
         if (i == RESET_CYCLES - 1) reset_2 <= 1'b1;
         @(negedge clk_suspend);
         check_outputs_idle();
      end
      // link held off, DIR low so the link owns the bus
      repeat (DISABLE_CYCLES) begin
         @(negedge clk_suspend);
         check_outputs_idle();
         check_bit("phy_d_oe", phy_d_oe, 1'b1);
      end
      @(posedge clk_suspend);
      opt_disable_all <= 1'b0;

      for (int s = 0; s < NSTEPS; s++) begin
         case (steps[s].op)
            OP_REGWR: expect_regwr(steps[s].a, steps[s].b);
            OP_RXCMD: send_rx_cmd(steps[s].a, steps[s].flag);
            OP_LOCAL: do @(negedge clk_suspend); while (reset_local !== steps[s].flag);
            OP_RECV:  receive_packet(int'(steps[s].b));
            OP_XMIT:  transmit_packet(steps[s].a, int'(steps[s].b));
            default: begin
               do @(negedge clk_suspend); while (se0_reset !== 1'b1);
               check_bit("pkt_in_cts", pkt_in_cts, 1'b0);
               @(negedge clk_suspend);
               check_bit("se0_reset", se0_reset, 1'b0);
            end
         endcase
      end
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: ulpi_link_fsm.sv
/*
 * Link controller. Runs the PHY start-up sequence, dispatches packet
 * transmit from idle, times SE0 for bus reset and restarts on Vbus loss.
 */
`default_nettype none

module ulpi_link_fsm #(
   parameter int TICK_CYCLES       = 256,
   parameter int DEBOUNCE_TICKS    = 2000,
   parameter int SE0_RESET_TICKS   = 710,
   parameter int PHY_RESET_TIMEOUT = 255
) (
   input  wire                  clk_suspend,
   input  wire                  reset_2,
   input  wire                  opt_disable_all,
   input  wire                  opt_ignore_vbus,
   input  wire                  phy_dir,
   input  wire ulpi_pkg::rx_cmd_t rx_cmd,
   input  wire                  dir_rise,
   input  wire                  rx_busy,
   input  wire                  pkt_in_latch,
   input  wire ulpi_pkg::ulpi_byte_t pkt_in_byte,
   ulpi_txcmd_if.ctrl           txcmd,
   output logic                 pkt_in_cts,
   output logic                 reset_local,
   output logic                 stat_connected,
   output logic                 se0_reset
);
   import ulpi_pkg::*;

   localparam int TICK_W   = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
   localparam int WRAP_MAX = (DEBOUNCE_TICKS > SE0_RESET_TICKS) ? DEBOUNCE_TICKS
                                                                : SE0_RESET_TICKS;
   localparam int WRAP_W   = $clog2(WRAP_MAX + 1);
   localparam int TO_W     = $clog2(PHY_RESET_TIMEOUT + 1);

   link_state_t       state;
   logic [TICK_W-1:0] tick_cnt;
   logic              tick;
   // tick count for debounce and SE0
   logic [WRAP_W-1:0] wrap;
   logic [TO_W-1:0]   to_cnt;
   logic              ign_1, ign_2;
   logic              vbus_valid, vbus_q;
   logic              latch_defer, pkt_req, se0_hit;

   assign tick           = (tick_cnt == TICK_W'(TICK_CYCLES - 1));
   assign vbus_valid     = (rx_cmd.vbus_state == VBUS_VALID);
   assign stat_connected = vbus_valid;
   assign se0_hit        = (wrap == WRAP_W'(SE0_RESET_TICKS));
   assign pkt_req        = pkt_in_latch | latch_defer;
   assign se0_reset      = (state == ST_IDLE) & ~rx_busy & se0_hit;
   assign pkt_in_cts     = (state == ST_IDLE) & ~rx_busy & ~se0_hit;

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         state       <= ST_RESET;
         tick_cnt    <= '0;
         wrap        <= '0;
         to_cnt      <= '0;
         ign_1       <= 1'b0;
         ign_2       <= 1'b0;
         vbus_q      <= 1'b0;
         latch_defer <= 1'b0;
         reset_local <= 1'b0;
         txcmd.start <= 1'b0;
      end else begin
         {ign_2, ign_1} <= {ign_1, opt_ignore_vbus};
         vbus_q         <= vbus_valid;
         tick_cnt       <= tick ? '0 : tick_cnt + TICK_W'(1);
         txcmd.start    <= 1'b0;
         // remember a latch the link could not take yet
         if (pkt_in_latch) latch_defer <= 1'b1;

         case (state)
            ST_RESET: begin
               wrap        <= '0;
               latch_defer <= 1'b0;
               if (!opt_disable_all) state <= ST_DEBOUNCE;
            end
            ST_DEBOUNCE: begin
               if (tick && wrap != WRAP_W'(DEBOUNCE_TICKS)) wrap <= wrap + WRAP_W'(1);
               if (!phy_dir && !txcmd.busy && wrap == WRAP_W'(DEBOUNCE_TICKS)) begin
                  txcmd.start <= 1'b1;
                  txcmd.code  <= TXCMD_REGWR;
                  txcmd.addr  <= REG_FUNC_CTRL;
                  txcmd.wdata <= FUNC_CTRL_PHY_RESET;
                  state       <= ST_PHY_RESET_WR;
               end
            end
            ST_PHY_RESET_WR: begin
               to_cnt <= '0;
               if (txcmd.done) state <= ST_PHY_RESET_WAIT;
            end
            ST_PHY_RESET_WAIT: begin
               // PHY raises DIR while in reset, else try again
               if (phy_dir) begin
                  state <= ST_FIRST_RXCMD;
               end else if (to_cnt == TO_W'(PHY_RESET_TIMEOUT)) begin
                  state <= ST_RESET;
               end else begin
                  to_cnt <= to_cnt + TO_W'(1);
               end
            end
            ST_FIRST_RXCMD: begin
               if (!rx_busy) begin
                  txcmd.start <= 1'b1;
                  txcmd.code  <= TXCMD_REGWR;
                  txcmd.addr  <= REG_OTG_CTRL;
                  txcmd.wdata <= OTG_CTRL_OFF;
                  state       <= ST_OTG_WR;
               end
            end
            ST_OTG_WR: begin
               if (txcmd.done) begin
                  reset_local <= 1'b1;
                  wrap        <= '0;
                  state       <= ST_IDLE;
               end
            end
            ST_IDLE: begin
               // align tick phase to each RX_CMD
               if (dir_rise) tick_cnt <= '0;
               if (rx_cmd.line_state != LINE_SE0) begin
                  wrap <= '0;
               end else if (tick && !se0_hit) begin
                  wrap <= wrap + WRAP_W'(1);
               end
               if (!rx_busy && se0_hit) begin
                  // bus reset, back to full speed
                  wrap        <= '0;
                  txcmd.start <= 1'b1;
                  txcmd.code  <= TXCMD_REGWR;
                  txcmd.addr  <= REG_FUNC_CTRL;
                  txcmd.wdata <= FUNC_CTRL_FS;
                  state       <= ST_SE0_WR;
               end else if (!rx_busy && pkt_req) begin
                  // first packet byte carries the PID
                  txcmd.start <= 1'b1;
                  txcmd.code  <= TXCMD_XMIT;
                  txcmd.pid   <= pkt_in_byte[3:0];
                  state       <= ST_PKT;
               end
            end
            ST_SE0_WR: if (txcmd.done) state <= ST_IDLE;
            ST_PKT: begin
               if (txcmd.done) begin
                  latch_defer <= 1'b0;
                  state       <= ST_IDLE;
               end
            end
            default: state <= ST_RESET;
         endcase

         ////////////////////
         // Vbus loss restarts the whole link
         if (!ign_2 && vbus_q && !vbus_valid) begin
            reset_local <= 1'b0;
            state       <= ST_RESET;
         end
      end
   end

endmodule

`default_nettype wire

// File: ulpi_pkg.sv
/*
 * Shared ULPI definitions for the full-speed device link.
 * Holds the TX_CMD classes, the PHY register map and values,
 * the RX_CMD field layout and the link controller states.
 */
`default_nettype none

package ulpi_pkg;

   // one byte on the ULPI data bus
   typedef logic [7:0] ulpi_byte_t;

   ////////////////////
   // TX_CMD classes, top two bits of the command byte
   typedef enum logic [1:0] {
      TXCMD_XMIT  = 2'b01,
      TXCMD_REGWR = 2'b10
   } txcmd_code_t;

   ////////////////////
   // immediate register addresses
   localparam logic [5:0] REG_FUNC_CTRL = 6'h04;
   localparam logic [5:0] REG_OTG_CTRL  = 6'h0A;

   // function control: SuspendM off, Reset, normal opmode, TermSelect, FS xcvr
   localparam ulpi_byte_t FUNC_CTRL_PHY_RESET = 8'h65;
   // same fields, reset bit clear
   localparam ulpi_byte_t FUNC_CTRL_FS        = 8'h45;
   // OTG pulldowns and ID pullup off
   localparam ulpi_byte_t OTG_CTRL_OFF        = 8'h00;

   ////////////////////
   // RX_CMD byte as sent by the PHY, msb first
   typedef struct packed {
      logic       alt_int;
      logic       id_gnd;
      logic [1:0] rx_event;
      logic [1:0] vbus_state;
      logic [1:0] line_state;
   } rx_cmd_t;

   localparam logic [1:0] VBUS_VALID = 2'b11;
   localparam logic [1:0] LINE_SE0   = 2'b00;

   ////////////////////
   // link controller states
   typedef enum logic [3:0] {
      ST_RESET,
      ST_DEBOUNCE,
      ST_PHY_RESET_WR,
      ST_PHY_RESET_WAIT,
      ST_FIRST_RXCMD,
      ST_OTG_WR,
      ST_IDLE,
      ST_SE0_WR,
      ST_PKT
   } link_state_t;

endpackage

`default_nettype wire

// File: ulpi_rx_decoder.sv
/*
 * ULPI receive side. Tracks DIR turnaround, keeps the latest RX_CMD
 * and passes received packet bytes straight up to the packet layer.
 */
`default_nettype none

module ulpi_rx_decoder (
   input  wire                  clk_suspend,
   input  wire                  reset_2,
   input  wire                  phy_dir,
   input  wire                  phy_nxt,
   input  wire ulpi_pkg::ulpi_byte_t phy_d_in,
   output ulpi_pkg::rx_cmd_t    rx_cmd,
   output logic                 dir_rise,
   output logic                 rx_busy,
   output logic                 pkt_out_act,
   output ulpi_pkg::ulpi_byte_t pkt_out_byte,
   output logic                 pkt_out_latch
);
   import ulpi_pkg::*;

   logic dir_q;
   // DIR and NXT rising together means packet data, not an RX_CMD
   logic know_recv;
   logic rx_active;

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         dir_q     <= 1'b0;
         know_recv <= 1'b0;
         rx_cmd    <= '0;
      end else begin
         dir_q <= phy_dir;
         if (dir_rise) begin
            know_recv <= phy_nxt;
         end else if (!phy_dir) begin
            know_recv <= 1'b0;
         end
         // past turnaround, NXT low marks an RX_CMD byte
         if (phy_dir && dir_q && !phy_nxt) begin
            rx_cmd <= rx_cmd_t'(phy_d_in);
         end
      end
   end

   assign dir_rise = phy_dir & ~dir_q;
   // stays up through the turnaround after DIR drops
   assign rx_busy  = phy_dir | dir_q;

   ////////////////////
   // packet layer receive path
   assign rx_active     = rx_cmd.rx_event[0];
   assign pkt_out_act   = (rx_active | know_recv) & phy_dir;
   // no data in the turnaround cycle
   assign pkt_out_latch = pkt_out_act & phy_nxt & dir_q;
   assign pkt_out_byte  = pkt_out_latch ? phy_d_in : '0;

   // only inside a receive, never in its turnaround cycle
   a_latch_in_rx: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      pkt_out_latch |-> phy_dir && $past(phy_dir));

endmodule

`default_nettype wire

// File: ulpi_tx_engine.sv
/*
 * ULPI transmit engine. Drives the data bus and STP for immediate
 * register writes and for packet transmit with a PID TX_CMD.
 * Takes one request at a time over the command channel.
 */
`default_nettype none

module ulpi_tx_engine (
   input  wire                  clk_suspend,
   input  wire                  reset_2,
   ulpi_txcmd_if.engine         txcmd,
   input  wire                  phy_dir,
   input  wire                  phy_nxt,
   input  wire ulpi_pkg::ulpi_byte_t pkt_in_byte,
   input  wire                  pkt_in_stp,
   output logic                 pkt_in_nxt,
   output ulpi_pkg::ulpi_byte_t phy_d_out_mux,
   output logic                 phy_d_oe,
   output logic                 phy_stp
);
   import ulpi_pkg::*;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_CMD,
      TX_DATA,
      TX_PKT,
      TX_STP
   } tx_state_t;

   tx_state_t  state;
   ulpi_byte_t d_out;
   logic       dir_q;

   always_ff @(posedge clk_suspend) begin
      if (!reset_2) begin
         state      <= TX_IDLE;
         d_out      <= '0;
         // bus released until DIR is known
         dir_q      <= 1'b1;
         phy_stp    <= 1'b0;
         txcmd.done <= 1'b0;
      end else begin
         dir_q      <= phy_dir;
         phy_stp    <= 1'b0;
         txcmd.done <= 1'b0;
         case (state)
            TX_IDLE: begin
               if (txcmd.start) begin
                  state <= TX_CMD;
                  // command byte, address or PID in the low bits
                  if (txcmd.code == TXCMD_REGWR) begin
                     d_out <= {txcmd.code, txcmd.addr};
                  end else begin
                     d_out <= {txcmd.code, 2'b00, txcmd.pid};
                  end
               end
            end
            TX_CMD: begin
               // hold the command byte until NXT
               if (phy_nxt) begin
                  if (txcmd.code == TXCMD_REGWR) begin
                     d_out <= txcmd.wdata;
                     state <= TX_DATA;
                  end else begin
                     d_out <= '0;
                     state <= TX_PKT;
                  end
               end
            end
            TX_DATA: begin
               if (phy_nxt) begin
                  d_out      <= '0;
                  phy_stp    <= 1'b1;
                  txcmd.done <= 1'b1;
                  state      <= TX_STP;
               end
            end
            TX_PKT: begin
               // packet layer owns the bus bytes here
               if (pkt_in_stp) begin
                  phy_stp    <= 1'b1;
                  txcmd.done <= 1'b1;
                  state      <= TX_STP;
               end
            end
            TX_STP: state <= TX_IDLE;
            default: state <= TX_IDLE;
         endcase
      end
   end

   assign txcmd.busy    = (state != TX_IDLE);
   assign phy_d_oe      = ~dir_q;
   assign phy_d_out_mux = (state == TX_PKT) ? pkt_in_byte : d_out;
   assign pkt_in_nxt    = phy_nxt & (state == TX_PKT);

   // link controller keeps to one request at a time
   a_start_idle: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      txcmd.start |-> !txcmd.busy);
   a_stp_single: assert property (@(posedge clk_suspend) disable iff (!reset_2)
      phy_stp |=> !phy_stp);

endmodule

`default_nettype wire

// File: ulpi_txcmd_if.sv
/*
 * Command channel from the link controller to the transmit engine.
 * ctrl pulses start while busy is low and holds the fields until done.
 */
`default_nettype none

interface ulpi_txcmd_if;
   import ulpi_pkg::*;

   // request side
   logic        start;
   txcmd_code_t code;
   logic [5:0]  addr;
   ulpi_byte_t  wdata;
   logic [3:0]  pid;

   // engine side
   logic        done;
   logic        busy;

   modport ctrl   (output start, code, addr, wdata, pid, input done, busy);
   modport engine (input start, code, addr, wdata, pid, output done, busy);

endinterface

`default_nettype wire

// File: usb2_ulpi_link.sv
/*
 * Full-speed USB 2.0 device link for a ULPI PHY, top level.
 * Connects the receive decoder, transmit engine and link controller.
 */
`default_nettype none

module usb2_ulpi_link #(
   parameter int TICK_CYCLES       = 256,
   parameter int DEBOUNCE_TICKS    = 2000,
   parameter int SE0_RESET_TICKS   = 710,
   parameter int PHY_RESET_TIMEOUT = 255
) (
   input  wire                  clk_suspend,
   input  wire                  reset_2,
   output logic                 reset_local,
   input  wire                  opt_disable_all,
   input  wire                  opt_ignore_vbus,
   output logic                 stat_connected,
   // ULPI PHY
   input  wire ulpi_pkg::ulpi_byte_t phy_d_in,
   output ulpi_pkg::ulpi_byte_t phy_d_out_mux,
   output logic                 phy_d_oe,
   input  wire                  phy_dir,
   output logic                 phy_stp,
   input  wire                  phy_nxt,
   // packet layer
   output logic                 pkt_out_act,
   output ulpi_pkg::ulpi_byte_t pkt_out_byte,
   output logic                 pkt_out_latch,
   output logic                 pkt_in_cts,
   output logic                 pkt_in_nxt,
   input  wire ulpi_pkg::ulpi_byte_t pkt_in_byte,
   input  wire                  pkt_in_latch,
   input  wire                  pkt_in_stp,
   output logic                 se0_reset
);
   import ulpi_pkg::*;

   rx_cmd_t rx_cmd;
   logic    dir_rise;
   logic    rx_busy;

   ulpi_txcmd_if txcmd ();

   ulpi_rx_decoder u_rx (
      .clk_suspend, .reset_2, .phy_dir, .phy_nxt, .phy_d_in,
      .rx_cmd, .dir_rise, .rx_busy,
      .pkt_out_act, .pkt_out_byte, .pkt_out_latch
   );

   ulpi_tx_engine u_tx (
      .clk_suspend, .reset_2, .txcmd (txcmd.engine), .phy_dir, .phy_nxt,
      .pkt_in_byte, .pkt_in_stp, .pkt_in_nxt,
      .phy_d_out_mux, .phy_d_oe, .phy_stp
   );

   ulpi_link_fsm #(
      .TICK_CYCLES       (TICK_CYCLES),
      .DEBOUNCE_TICKS    (DEBOUNCE_TICKS),
      .SE0_RESET_TICKS   (SE0_RESET_TICKS),
      .PHY_RESET_TIMEOUT (PHY_RESET_TIMEOUT)
   ) u_fsm (
      .clk_suspend, .reset_2, .opt_disable_all, .opt_ignore_vbus, .phy_dir,
      .rx_cmd, .dir_rise, .rx_busy, .pkt_in_latch, .pkt_in_byte,
      .txcmd (txcmd.ctrl), .pkt_in_cts, .reset_local, .stat_connected, .se0_reset
   );

endmodule

`default_nettype wire
